// File: common/audio_pkg.sv
package audio_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    localparam int SAMPLE_W   = 24;   // pcm sample width
    localparam int COEF_W     = 16;   // signed q1.15
    localparam int MAX_TAPS   = 16;   // coef memory and delay line depth
    localparam int TAP_ADDR_W = 4;    // tap / coef index width
    localparam int ACC_W      = 48;   // mac accumulator
    localparam int FRAC_SHIFT = 15;   // drop q1.15 fraction before saturation

    ////////////////////////////////////////
    // shared types
    ////////////////////////////////////////

    // one stereo sample
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] left;
        logic signed [SAMPLE_W-1:0] right;
    } pcm_pair_t;

    // one set of i2s lines
    typedef struct packed {
        logic sclk;    // system clock line, passed along only
        logic bclk;    // bit clock
        logic lrclk;   // word select, low = left
        logic data;    // serial data, msb first
    } i2s_bus_t;

    // coef word as the host writes it
    typedef struct packed {
        logic [7:0] msb;
        logic [7:0] lsb;
    } coef_bytes_t;

    // host sees byte pairs, the mac sees a signed value
    typedef union packed {
        coef_bytes_t              bytes;
        logic signed [COEF_W-1:0] value;
    } coef_word_u;

    // host control byte, field order puts bypass in bit 0
    typedef struct packed {
        logic [4:0] reserved;
        logic       coef_rst;       // bit 2, level
        logic       audio_enable;   // bit 1
        logic       bypass;         // bit 0
    } audio_ctrl_t;

endpackage

// File: i2s/i2s_rx.sv
`timescale 1ns/1ns

module i2s_rx import audio_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  i2s_bus_t  i2s_in,
    output pcm_pair_t rx_pcm,
    output logic      l_stb,
    output logic      r_stb,
    output i2s_bus_t  bus_sync
);

    ////////////////////////////////////////
    // line synchronizer
    ////////////////////////////////////////

    i2s_bus_t sync_q1;
    i2s_bus_t sync_q2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= i2s_in;
            sync_q2 <= sync_q1;
        end
    end

    assign bus_sync = sync_q2;   // tx reuses these clocks

    ////////////////////////////////////////
    // deserializer
    ////////////////////////////////////////

    logic                bclk_prev;   // for edge detect
    logic                lr_prev;     // lrclk at last bclk rise
    logic [SAMPLE_W-1:0] shift_q;
    logic [4:0]          bit_cnt;     // rises since last lrclk change, saturating
    logic                bclk_rise;
    logic                lr_change;
    logic [SAMPLE_W-1:0] word_done;

    assign bclk_rise = sync_q2.bclk & ~bclk_prev;
    assign lr_change = sync_q2.lrclk ^ lr_prev;

    // lsb of a word lands on the first rise after lrclk flips (1 bit i2s delay)
    assign word_done = {shift_q[SAMPLE_W-2:0], sync_q2.data};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bclk_prev <= 1'b0;
            lr_prev   <= 1'b0;
            shift_q   <= '0;
            bit_cnt   <= '0;
            rx_pcm    <= '0;
            l_stb     <= 1'b0;
            r_stb     <= 1'b0;
        end else begin
            bclk_prev <= sync_q2.bclk;
            l_stb     <= 1'b0;
            r_stb     <= 1'b0;
            if (bclk_rise) begin
                shift_q <= word_done;
                lr_prev <= sync_q2.lrclk;
                if (lr_change) begin
                    bit_cnt <= '0;
                    // drop partial words seen right after reset
                    if (bit_cnt >= 5'(SAMPLE_W - 1)) begin
                        if (lr_prev) begin
                            rx_pcm.right <= word_done;
                            r_stb        <= 1'b1;
                        end else begin
                            rx_pcm.left <= word_done;
                            l_stb       <= 1'b1;
                        end
                    end
                end else if (bit_cnt != 5'h1f) begin
                    bit_cnt <= bit_cnt + 5'd1;
                end
            end
        end
    end

endmodule

// File: i2s/i2s_tx.sv
`timescale 1ns/1ns

module i2s_tx import audio_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  i2s_bus_t  bus_sync,
    input  pcm_pair_t tx_pcm,
    output i2s_bus_t  tx_bus
);

    logic [SAMPLE_W-1:0] shift_q;   // word in flight, msb at the top
    logic                bclk_fall;
    logic                lr_change;

    // tx_bus holds last cycle's clocks, so it doubles as the edge detector
    assign bclk_fall = tx_bus.bclk & ~bus_sync.bclk;
    assign lr_change = tx_bus.lrclk ^ bus_sync.lrclk;

    ////////////////////////////////////////
    // serializer
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shift_q      <= '0;
            tx_bus.data  <= 1'b0;
        end else if (bclk_fall) begin
            // top bit goes out first, which on an lrclk change is the
            // old word's lsb, giving the one bit i2s delay
            tx_bus.data <= shift_q[SAMPLE_W-1];
            if (lr_change) begin
                // new slot, grab the latest filter result for it
                shift_q <= bus_sync.lrclk ? tx_pcm.right : tx_pcm.left;
            end else begin
                shift_q <= {shift_q[SAMPLE_W-2:0], 1'b0};
            end
        end
    end

    ////////////////////////////////////////
    // clock pass-through
    ////////////////////////////////////////

    // clocks take the same one-cycle delay as data, edges line up at the dac
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_bus.sclk  <= 1'b0;
            tx_bus.bclk  <= 1'b0;
            tx_bus.lrclk <= 1'b0;
        end else begin
            tx_bus.sclk  <= bus_sync.sclk;
            tx_bus.bclk  <= bus_sync.bclk;
            tx_bus.lrclk <= bus_sync.lrclk;
        end
    end

    // data changes on the cycle bclk falls at the output, dac samples on rise
    // half a bit later, so nothing else is needed for alignment

endmodule

// File: fir/fir_coef_ram.sv
`timescale 1ns/1ns

module fir_coef_ram import audio_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  coef_rst,
    input  logic                  coef_wr_en,
    input  logic [7:0]            coef_wr_lsb,
    input  logic [7:0]            coef_wr_msb,
    input  logic [TAP_ADDR_W-1:0] rd_addr,
    output coef_word_u            rd_coef,
    output logic                  wr_addr_zero
);

    coef_word_u            mem [MAX_TAPS];
    logic [TAP_ADDR_W-1:0] wr_ptr;
    coef_word_u            wr_word;
    logic                  wr_go;

    assign wr_word.bytes.msb = coef_wr_msb;
    assign wr_word.bytes.lsb = coef_wr_lsb;
    assign wr_go = coef_wr_en & ~coef_rst;   // no writes while pointer is held

    // pointer, wraps at MAX_TAPS by width
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
        end else if (coef_rst) begin
            wr_ptr <= '0;   // level, contents untouched
        end else if (wr_go) begin
            wr_ptr <= wr_ptr + TAP_ADDR_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    assign rd_coef      = mem[rd_addr];        // async read for the mac
    assign wr_addr_zero = (wr_ptr == '0);

endmodule

// File: fir/fir_filter.sv
`timescale 1ns/1ns

module fir_filter import audio_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  audio_enable,
    input  logic [7:0]            taps_per_filter,
    input  pcm_pair_t             in_pcm,
    input  logic                  l_stb,
    input  logic                  r_stb,
    output logic [TAP_ADDR_W-1:0] coef_rd_addr,
    input  coef_word_u            coef_rd,
    output pcm_pair_t             fir_out,
    output logic                  done_l,
    output logic                  done_r
);

    logic signed [SAMPLE_W-1:0] dl_l [MAX_TAPS];   // x[n-k] at index k
    logic signed [SAMPLE_W-1:0] dl_r [MAX_TAPS];

    logic                  mac_busy;   // one tap per cycle
    logic                  mac_fin;    // round and write back
    logic                  mac_ch;     // 0 = left, 1 = right
    logic [TAP_ADDR_W-1:0] tap_idx;
    logic [TAP_ADDR_W-1:0] last_idx;
    logic                  start;

    logic signed [SAMPLE_W-1:0] tap_sample;
    logic signed [ACC_W-1:0]    product;
    logic signed [ACC_W-1:0]    acc;
    logic signed [ACC_W-1:0]    rounded;
    logic signed [ACC_W-1:0]    scaled;
    logic                       sat_hi;
    logic                       sat_lo;
    logic [SAMPLE_W-1:0]        sat_result;

    ////////////////////////////////////////
    // shared datapath
    ////////////////////////////////////////

    assign start        = (l_stb | r_stb) & audio_enable;
    assign coef_rd_addr = tap_idx;
    assign tap_sample   = mac_ch ? dl_r[tap_idx] : dl_l[tap_idx];
    assign product      = ACC_W'(coef_rd.value) * ACC_W'(tap_sample);   // single multiplier

    // round half up, drop fraction, clamp to 24 bits
    assign rounded = acc + (ACC_W'(1) <<< (FRAC_SHIFT - 1));
    assign scaled  = rounded >>> FRAC_SHIFT;
    assign sat_hi  = ~scaled[ACC_W-1] & (|scaled[ACC_W-2:SAMPLE_W-1]);
    assign sat_lo  = scaled[ACC_W-1] & ~(&scaled[ACC_W-2:SAMPLE_W-1]);

    always_comb begin
        if (sat_hi) begin
            sat_result = {1'b0, {(SAMPLE_W-1){1'b1}}};
        end else if (sat_lo) begin
            sat_result = {1'b1, {(SAMPLE_W-1){1'b0}}};
        end else begin
            sat_result = scaled[SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
        end else if (mac_busy) begin
            acc <= acc + product;
        end
    end

    ////////////////////////////////////////
    // control and delay lines
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mac_busy <= 1'b0;
            mac_fin  <= 1'b0;
            mac_ch   <= 1'b0;
            tap_idx  <= '0;
            last_idx <= '0;
            done_l   <= 1'b0;
            done_r   <= 1'b0;
            fir_out  <= '0;
            for (int k = 0; k < MAX_TAPS; k++) begin
                dl_l[k] <= '0;
                dl_r[k] <= '0;
            end
        end else begin
            done_l <= 1'b0;
            done_r <= 1'b0;
            if (start) begin
                mac_busy <= 1'b1;
                mac_ch   <= ~l_stb;
                tap_idx  <= '0;
                // taps of 0 means 16, the subtract wraps to 15
                last_idx <= taps_per_filter[TAP_ADDR_W-1:0] - TAP_ADDR_W'(1);
                for (int k = MAX_TAPS - 1; k > 0; k--) begin
                    if (l_stb) dl_l[k] <= dl_l[k-1];
                    else       dl_r[k] <= dl_r[k-1];
                end
                if (l_stb) dl_l[0] <= in_pcm.left;
                else       dl_r[0] <= in_pcm.right;
            end else if (l_stb | r_stb) begin
                // filter off, straight copy and delay lines frozen
                if (l_stb) fir_out.left  <= in_pcm.left;
                if (r_stb) fir_out.right <= in_pcm.right;
            end else if (mac_busy) begin
                tap_idx <= tap_idx + TAP_ADDR_W'(1);
                if (tap_idx == last_idx) begin
                    mac_busy <= 1'b0;
                    mac_fin  <= 1'b1;
                end
            end else if (mac_fin) begin
                mac_fin <= 1'b0;   // done lands taps+2 after the strobe
                if (mac_ch) begin
                    fir_out.right <= sat_result;
                    done_r        <= 1'b1;
                end else begin
                    fir_out.left <= sat_result;
                    done_l       <= 1'b1;
                end
            end
        end
    end

endmodule

// File: design/audio_proc_top.sv
`timescale 1ns/1ns

module audio_proc_top import audio_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  i2s_bus_t    i2s_in,
    input  audio_ctrl_t ctrl,
    input  logic [7:0]  taps_per_filter,
    input  logic        coef_wr_en,
    input  logic [7:0]  coef_wr_lsb,
    input  logic [7:0]  coef_wr_msb,
    output i2s_bus_t    dac,
    output logic        dac_rst,
    output logic        wr_addr_zero
);

    ////////////////////////////////////////
    // control byte
    ////////////////////////////////////////

    logic bypass;
    logic audio_enable;
    logic coef_rst;

    assign bypass       = ctrl.bypass;
    assign audio_enable = ctrl.audio_enable;
    assign coef_rst     = ctrl.coef_rst;
    assign dac_rst      = ~arst_n;   // dac held in reset with us

    pcm_pair_t             rx_pcm;
    logic                  l_stb;
    logic                  r_stb;
    i2s_bus_t              bus_sync;
    logic [TAP_ADDR_W-1:0] coef_rd_addr;
    coef_word_u            coef_rd;
    pcm_pair_t             fir_out;
    i2s_bus_t              tx_bus;

    i2s_rx rx_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .i2s_in   (i2s_in),
        .rx_pcm   (rx_pcm),
        .l_stb    (l_stb),
        .r_stb    (r_stb),
        .bus_sync (bus_sync)
    );

    fir_coef_ram coef_ram_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .coef_rst     (coef_rst),
        .coef_wr_en   (coef_wr_en),
        .coef_wr_lsb  (coef_wr_lsb),
        .coef_wr_msb  (coef_wr_msb),
        .rd_addr      (coef_rd_addr),
        .rd_coef      (coef_rd),
        .wr_addr_zero (wr_addr_zero)
    );

    fir_filter fir_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .audio_enable    (audio_enable),
        .taps_per_filter (taps_per_filter),
        .in_pcm          (rx_pcm),
        .l_stb           (l_stb),
        .r_stb           (r_stb),
        .coef_rd_addr    (coef_rd_addr),
        .coef_rd         (coef_rd),
        .fir_out         (fir_out),
        .done_l          (),   // tx picks results up on lrclk, no need here
        .done_r          ()
    );

    i2s_tx tx_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .bus_sync (bus_sync),
        .tx_pcm   (fir_out),
        .tx_bus   (tx_bus)
    );

    ////////////////////////////////////////
    // dac output mux
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dac <= '0;
        end else begin
            dac <= bypass ? i2s_in : tx_bus;   // raw lines or processed, one flop either way
        end
    end

endmodule

// File: tb/audio_sva.sv
`timescale 1ns/1ns

module audio_sva (
    input logic clk,
    input logic arst_n,
    input logic l_stb,
    input logic r_stb,
    input logic mac_busy,
    input logic mac_fin,
    input logic done_l,
    input logic done_r
);

    // sample rate keeps the mac idle whenever a new word lands
    property strobe_when_idle;
        @(posedge clk) disable iff (!arst_n)
            (l_stb || r_stb) |-> !(mac_busy || mac_fin);
    endproperty

    property done_l_single;
        @(posedge clk) disable iff (!arst_n) done_l |=> !done_l;
    endproperty

    property done_r_single;
        @(posedge clk) disable iff (!arst_n) done_r |=> !done_r;
    endproperty

    // no disable here, reset is the condition itself
    property done_quiet_in_reset;
        @(posedge clk) !arst_n |-> !(done_l || done_r);
    endproperty

    a_strobe_idle: assert property (strobe_when_idle)
        else $error("fir strobe arrived while the mac was busy");
    a_done_l: assert property (done_l_single)
        else $error("done_l held high for more than one cycle");
    a_done_r: assert property (done_r_single)
        else $error("done_r held high for more than one cycle");
    a_reset: assert property (done_quiet_in_reset)
        else $error("done pulse seen during reset");

endmodule

bind fir_filter audio_sva sva_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .l_stb    (l_stb),
    .r_stb    (r_stb),
    .mac_busy (mac_busy),
    .mac_fin  (mac_fin),
    .done_l   (done_l),
    .done_r   (done_r)
);

// File: tb/audio_checker.sv
`timescale 1ns/1ns

module audio_checker import audio_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  i2s_bus_t   dac,
    input  logic       dac_rst,
    input  logic       wr_addr_zero,
    input  logic       exp_push,      // one expected dac frame per pulse
    input  logic [7:0] exp_test,
    input  pcm_pair_t  exp_pair,
    input  logic       exp_check,     // 0 = frame is decoded but not compared
    input  logic       zero_chk,
    input  logic       zero_exp,
    input  logic       report_last,
    output int         pending,
    output int         check_count,
    output int         err_count
);

    pcm_pair_t  q_pair [$];
    logic [7:0] q_test [$];
    logic       q_chk  [$];

    logic                bclk_seen;
    logic                lr_seen;
    logic [SAMPLE_W-1:0] word;
    logic [SAMPLE_W-1:0] left_word;
    int                  run_len;     // bits since the last word select flip
    int                  cur_test;
    int                  test_checks;
    int                  test_errs;
    logic                rst_err_seen;   // stuck dac_rst is reported once

    ////////////////////////////////////////
    // per test summary
    ////////////////////////////////////////

    task automatic report_test();
        if (cur_test < 0) return;
        if (test_errs == 0)
            $display("test %0d: ok, %0d frames checked", cur_test, test_checks);
        else
            $display("test %0d: FAILED, %0d mismatches", cur_test, test_errs);
    endtask

    task automatic compare_frame(input pcm_pair_t got);
        pcm_pair_t  exp;
        logic [7:0] tid;
        logic       chk;
        if (q_pair.size() == 0) begin
            $display("unexpected DAC frame decoded with no expected values queued");
            err_count++;
            return;
        end
        exp = q_pair.pop_front();
        tid = q_test.pop_front();
        chk = q_chk.pop_front();
        if (int'(tid) != cur_test) begin   // previous test is over
            report_test();
            cur_test    = int'(tid);
            test_checks = 0;
            test_errs   = 0;
        end
        if (chk) begin
            check_count++;
            test_checks++;
            if (got.left !== exp.left) begin
                $display("Mismatch dac left (test %0d): got %06h expected %06h",
                         cur_test, got.left, exp.left);
                err_count++;
                test_errs++;
            end
            if (got.right !== exp.right) begin
                $display("Mismatch dac right (test %0d): got %06h expected %06h",
                         cur_test, got.right, exp.right);
                err_count++;
                test_errs++;
            end
        end
    endtask

    ////////////////////////////////////////
    // dac stream decode
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!arst_n) begin
            bclk_seen = 1'b0;
            lr_seen   = 1'b0;
            word      = '0;
            left_word = '0;
            run_len   = 0;
        end else begin
            if (dac.bclk && !bclk_seen) begin   // dac samples on rising bclk
                word = {word[SAMPLE_W-2:0], dac.data};
                if (dac.lrclk != lr_seen) begin
                    // this bit is the lsb of the slot just closed
                    if (run_len >= SAMPLE_W - 1) begin
                        if (lr_seen) compare_frame({left_word, word});
                        else         left_word = word;
                    end
                    run_len = 0;
                end else begin
                    run_len++;
                end
                lr_seen = dac.lrclk;
            end
            bclk_seen = dac.bclk;
        end
        if (exp_push) begin
            q_pair.push_back(exp_pair);
            q_test.push_back(exp_test);
            q_chk.push_back(exp_check);
        end
        // dac reset line mirrors the system reset
        if (dac_rst !== !arst_n && !rst_err_seen) begin
            $display("Mismatch dac_rst: got %h expected %h", dac_rst, !arst_n);
            err_count++;
            rst_err_seen = 1'b1;
        end
        if (zero_chk) begin
            check_count++;
            if (wr_addr_zero !== zero_exp) begin
                $display("Mismatch wr_addr_zero: got %h expected %h", wr_addr_zero, zero_exp);
                err_count++;
            end
        end
        if (report_last) report_test();
        pending = q_pair.size();
    end

    initial begin
        pending      = 0;
        check_count  = 0;
        err_count    = 0;
        cur_test     = -1;
        test_checks  = 0;
        test_errs    = 0;
        rst_err_seen = 1'b0;
    end

endmodule

// File: tb/audio_tb.sv
`timescale 1ns/1ns

module audio_tb import audio_pkg::*; ();

    logic        clk;
    logic        arst_n;
    i2s_bus_t    i2s_in;
    audio_ctrl_t ctrl;
    logic [7:0]  taps_per_filter;
    logic        coef_wr_en;
    logic [7:0]  coef_wr_lsb;
    logic [7:0]  coef_wr_msb;
    i2s_bus_t    dac;
    logic        dac_rst;
    logic        wr_addr_zero;

    logic       exp_push;
    logic [7:0] exp_test;
    pcm_pair_t  exp_pair;
    logic       exp_check;
    logic       zero_chk;
    logic       zero_exp;
    logic       report_last;
    int         pending;
    int         check_count;
    int         err_count;

    logic [SAMPLE_W-1:0] prev_right;     // its lsb opens the next frame
    int                  wr_ptr_model;   // expected coef write pointer

    audio_proc_top audio_proc_top_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .i2s_in          (i2s_in),
        .ctrl            (ctrl),
        .taps_per_filter (taps_per_filter),
        .coef_wr_en      (coef_wr_en),
        .coef_wr_lsb     (coef_wr_lsb),
        .coef_wr_msb     (coef_wr_msb),
        .dac             (dac),
        .dac_rst         (dac_rst),
        .wr_addr_zero    (wr_addr_zero)
    );

    audio_checker chk_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .dac          (dac),
        .dac_rst      (dac_rst),
        .wr_addr_zero (wr_addr_zero),
        .exp_push     (exp_push),
        .exp_test     (exp_test),
        .exp_pair     (exp_pair),
        .exp_check    (exp_check),
        .zero_chk     (zero_chk),
        .zero_exp     (zero_exp),
        .report_last  (report_last),
        .pending      (pending),
        .check_count  (check_count),
        .err_count    (err_count)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // i2s source, bclk = 8 clk
    ////////////////////////////////////////

    task automatic drive_bit(input logic lr, input logic bit_val);
        @(posedge clk);
        i2s_in.bclk  <= 1'b0;   // falling edge, data and lrclk move
        i2s_in.lrclk <= lr;
        i2s_in.data  <= bit_val;
        repeat (4) @(posedge clk);
        i2s_in.bclk  <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    task automatic send_frame(input logic [SAMPLE_W-1:0] left, input logic [SAMPLE_W-1:0] right);
        logic b;
        for (int i = 0; i < 2 * SAMPLE_W; i++) begin
            if (i == 0)              b = prev_right[0];        // one bit i2s delay
            else if (i < SAMPLE_W)   b = left[SAMPLE_W - i];
            else if (i == SAMPLE_W)  b = left[0];
            else                     b = right[2 * SAMPLE_W - i];
            drive_bit(i >= SAMPLE_W, b);
        end
        prev_right = right;
        repeat (($urandom % 16) + 2) @(posedge clk);   // jittered idle gap
    endtask

    task automatic write_coef(input logic [7:0] msb, input logic [7:0] lsb);
        @(posedge clk);
        coef_wr_en  <= 1'b1;
        coef_wr_msb <= msb;
        coef_wr_lsb <= lsb;
        @(posedge clk);
        coef_wr_en  <= 1'b0;
        if (!ctrl.coef_rst) begin
            wr_ptr_model = (wr_ptr_model + 1) % MAX_TAPS;   // wraps at 16
        end
        zero_exp <= (wr_ptr_model == 0);   // pointer moved on this edge
        zero_chk <= 1'b1;
        @(posedge clk);
        zero_chk <= 1'b0;
    endtask

    task automatic apply_config(input logic [7:0] cv, input logic [7:0] taps, input logic zexp);
        audio_ctrl_t cfg;
        cfg = audio_ctrl_t'(cv);
        if (cfg.coef_rst) begin
            wr_ptr_model = 0;   // pointer held at zero
        end
        @(posedge clk);
        ctrl            <= cfg;
        taps_per_filter <= taps;
        repeat (2) @(posedge clk);   // pointer settles, then checked
        zero_exp <= zexp;
        zero_chk <= 1'b1;
        @(posedge clk);
        zero_chk <= 1'b0;
    endtask

    task automatic queue_expect(input int tid, input logic [SAMPLE_W-1:0] l,
                                input logic [SAMPLE_W-1:0] r, input int c);
        @(posedge clk);
        exp_push       <= 1'b1;
        exp_test       <= 8'(tid);
        exp_pair.left  <= l;
        exp_pair.right <= r;
        exp_check      <= (c != 0);
        @(posedge clk);
        exp_push       <= 1'b0;
    endtask

    ////////////////////////////////////////
    // trace driven run
    ////////////////////////////////////////

    initial begin
        int                  fd;
        int                  n;
        int                  tid;
        int                  chk;
        int                  last_tid;
        int                  tests;
        int                  wait_cnt;
        logic                failed;
        logic [7:0]          hx_a;
        logic [7:0]          hx_b;
        logic [SAMPLE_W-1:0] l_val;
        logic [SAMPLE_W-1:0] r_val;
        string               line;
        string               cmd;

        clk             = 1'b0;
        arst_n          = 1'b0;
        i2s_in          = '0;
        ctrl            = '0;
        taps_per_filter = 8'd1;
        coef_wr_en      = 1'b0;
        coef_wr_lsb     = '0;
        coef_wr_msb     = '0;
        exp_push        = 1'b0;
        exp_test        = '0;
        exp_pair        = '0;
        exp_check       = 1'b0;
        zero_chk        = 1'b0;
        zero_exp        = 1'b0;
        report_last     = 1'b0;
        prev_right      = '0;
        wr_ptr_model    = 0;
        failed          = 1'b0;
        last_tid        = -1;
        tests           = 0;
        void'($urandom(32'h9927_b89b));

        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) @(posedge clk);

        fd = $fopen("tb/audio_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file tb/audio_trace.txt");
            failed = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n == 0) break;
                if (line.len() < 2 || line[0] == "#") continue;   // comments, blanks
                n = $sscanf(line, "%s", cmd);
                if (cmd == "config") begin
                    n = $sscanf(line, "%s %d %h %h %d", cmd, tid, hx_a, hx_b, chk);
                    if (tid != last_tid) tests++;
                    last_tid = tid;
                    apply_config(hx_a, hx_b, chk != 0);
                end else if (cmd == "coef") begin
                    n = $sscanf(line, "%s %h %h", cmd, hx_a, hx_b);
                    write_coef(hx_a, hx_b);
                end else if (cmd == "expect") begin
                    n = $sscanf(line, "%s %d %h %h %d", cmd, tid, l_val, r_val, chk);
                    queue_expect(tid, l_val, r_val, chk);
                end else if (cmd == "frame") begin
                    n = $sscanf(line, "%s %h %h", cmd, l_val, r_val);
                    send_frame(l_val, r_val);
                end else begin
                    $display("unknown trace command: %s", cmd);
                    failed = 1'b1;
                end
            end
            $fclose(fd);
        end

        // last frame stays open, its right lsb never comes
        wait_cnt = 0;
        while (pending > 1 && wait_cnt < 20000) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (pending > 1) begin
            $display("timeout: %0d expected DAC frames were never decoded", pending - 1);
            failed = 1'b1;
        end

        @(posedge clk);
        report_last <= 1'b1;
        @(posedge clk);
        report_last <= 1'b0;
        repeat (2) @(posedge clk);

        $display("tests %0d, checks %0d, errors %0d", tests, check_count, err_count);
        if (!failed && err_count == 0 && check_count > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: tb/audio_trace.txt
# config <test> <ctrl hex> <taps hex> <wr_addr_zero>    coef <msb hex> <lsb hex>
# expect <test> <left hex> <right hex> <check>  (dac frame during the next frame)    frame <left> <right>
config 1 01 01 1
expect 1 123456 654321 1
frame 123456 654321
expect 1 800000 7fffff 1
frame 800000 7fffff
expect 1 000001 ffffff 1
frame 000001 ffffff
expect 1 000000 000000 0
frame 000000 000000
config 2 00 01 1
expect 2 000000 000000 1
frame 111111 222222
expect 2 111111 222222 1
frame abcdef fedcba
expect 2 abcdef fedcba 1
frame 000000 000000
config 3 06 01 1
config 3 02 01 1
coef 40 00
expect 3 000000 000000 1
frame 000003 fffffd
expect 3 000002 ffffff 1
frame 7fffff 800000
expect 3 400000 c00000 1
frame 000000 000000
config 4 06 04 1
config 4 02 04 1
coef 40 00
coef 20 00
coef c0 00
coef 10 00
expect 4 000000 000000 0
frame 000000 000000
expect 4 000000 000000 0
frame 000000 000000
expect 4 000000 000000 0
frame 000000 000000
expect 4 000000 000000 1
frame 000000 000000
expect 4 000000 000000 1
frame 100000 000000
expect 4 080000 000000 1
frame 000000 000000
expect 4 040000 000000 1
frame 000000 000000
expect 4 f80000 000000 1
frame 000000 000000
expect 4 020000 000000 1
frame 000000 000000
config 5 06 02 1
config 5 02 02 1
coef 7f ff
coef 7f ff
expect 5 000000 000000 1
frame 7fffff 800000
expect 5 7ffeff 800100 1
frame 7fffff 800000
expect 5 7fffff 800000 1
frame 000000 000000
expect 5 7ffeff 800100 1
frame 000000 000000
config 6 06 01 1
config 6 02 01 1
coef 20 00
expect 6 000000 000000 1
frame 000100 ffff00
expect 6 000040 ffffc0 1
frame 000000 000000
expect 6 000000 000000 0
frame 000000 000000

// File: sim.f
common/audio_pkg.sv
i2s/i2s_rx.sv
i2s/i2s_tx.sv
fir/fir_coef_ram.sv
fir/fir_filter.sv
design/audio_proc_top.sv
tb/audio_sva.sv
tb/audio_checker.sv
tb/audio_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module audio_tb -f sim.f

sim:
	verilator --binary --timing --assert --top-module audio_tb -f sim.f -o audio_sim
	./obj_dir/audio_sim | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
